// ==== common/fbPkg.sv ====
package fbPkg;

	////////////////////////////////////////////////////////////
	// Stored image geometry.
	////////////////////////////////////////////////////////////
	localparam int fbWidth = 160;
	localparam int fbHeight = 120;
	localparam int fbPixels = fbWidth * fbHeight; // Depth of one bank.
	localparam int scaleShift = 2; // 4x upscale on both axes.
	localparam int fbAddrW = 15;
	localparam int palDepth = 8;

	////////////////////////////////////////////////////////////
	// VGA 640x480 timing at the 25 MHz pixel clock.
	////////////////////////////////////////////////////////////
	localparam int cntW = 10;
	localparam int hActive = 640;
	localparam int hFront = 16;
	localparam int hSync = 96;
	localparam int hBack = 48;
	localparam int hSyncStart = hActive + hFront;
	localparam int hSyncEnd = hSyncStart + hSync;
	localparam int hTotal = hSyncEnd + hBack; // 800.
	localparam int vActive = 480;
	localparam int vFront = 10;
	localparam int vSync = 2;
	localparam int vBack = 33;
	localparam int vSyncStart = vActive + vFront;
	localparam int vSyncEnd = vSyncStart + vSync;
	localparam int vTotal = vSyncEnd + vBack; // 525.

	typedef logic [2:0] pixelT; // Palette index.
	typedef logic [11:0] colorT; // 4 bits each of R, G, B.
	typedef logic [fbAddrW-1:0] fbAddrT;
	typedef logic [cntW-1:0] cntT;

	// Register map.
	localparam int axiAddrW = 8;
	localparam logic [axiAddrW-1:0] regCtrl = 8'h00;
	localparam logic [axiAddrW-1:0] regPixel = 8'h04;
	localparam logic [axiAddrW-1:0] regPaletteBase = 8'h20;

endpackage

// ==== compile.f ====
+incdir+test
common/fbPkg.sv
frameBuffer/dualPortRam.sv
frameBuffer/frameBuffer.sv
scanout/vgaTiming.sv
scanout/pixelPipe.sv
src/axiLiteRegs.sv
src/displayTop.sv
test/displayTb.sv

// ==== frameBuffer/dualPortRam.sv ====
`timescale 1ns/1ps

module dualPortRam
#(
	parameter type dataT = logic,
	parameter int depth = 8
)
(
	input  logic clk,
	input  logic we,
	input  logic [$clog2(depth)-1:0] wrAddr,
	input  dataT wrData,
	input  logic [$clog2(depth)-1:0] rdAddr,
	output dataT rdData
);

	dataT mem [depth];

	// Power up blank.
	initial
	begin
		for (int i = 0; i < depth; i++)
			mem[i] = '0;
	end

	////////////////////////////////////////////////////////////
	// One write port, one registered read port.
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (we)
			mem[wrAddr] <= wrData;
		rdData <= mem[rdAddr]; // Old value on a same-address write.
	end

endmodule

// ==== frameBuffer/frameBuffer.sv ====
`timescale 1ns/1ps

module frameBuffer
(
	input  logic clk,
	input  logic reset,
	input  logic pixWe,
	input  fbPkg::fbAddrT pixAddr,
	input  fbPkg::pixelT pixData,
	input  logic swapReq,
	input  logic frameEnd,
	input  fbPkg::fbAddrT rdAddr,
	output fbPkg::pixelT rdPixel,
	output logic frontBank,
	output logic swapPending
);

	logic we0;
	logic we1;
	logic frontQ; // Bank bit aligned with the RAM output.
	fbPkg::pixelT rd0;
	fbPkg::pixelT rd1;

	// Painter only ever touches the back bank.
	assign we0 = pixWe && frontBank;
	assign we1 = pixWe && !frontBank;
	assign rdPixel = frontQ ? rd1 : rd0;

	////////////////////////////////////////////////////////////
	// Deferred swap.
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			frontBank <= 1'b0;
			swapPending <= 1'b0;
			frontQ <= 1'b0;
		end
		else
		begin
			frontQ <= frontBank;
			if (frameEnd && swapPending)
			begin
				frontBank <= !frontBank; // Flip in vertical blank only.
				swapPending <= 1'b0;
			end
			else if (swapReq)
				swapPending <= 1'b1; // Repeat requests fold into one.
		end
	end

	dualPortRam #(
		.dataT(fbPkg::pixelT),
		.depth(fbPkg::fbPixels)
	) bank0 (
		.clk(clk),
		.we(we0),
		.wrAddr(pixAddr),
		.wrData(pixData),
		.rdAddr(rdAddr), // Both banks read, mux picks front.
		.rdData(rd0)
	);

	dualPortRam #(
		.dataT(fbPkg::pixelT),
		.depth(fbPkg::fbPixels)
	) bank1 (
		.clk(clk),
		.we(we1),
		.wrAddr(pixAddr),
		.wrData(pixData),
		.rdAddr(rdAddr),
		.rdData(rd1)
	);

	aSwapAtFrameEnd: assert property (@(posedge clk) disable iff (reset)
		$changed(frontBank) |-> $past(frameEnd))
		else $error("front bank changed mid frame");

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then judge the log.
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module displayTb -o displayTb > build.log 2>&1 &&
./obj_dir/displayTb > sim.log 2>&1
cat build.log sim.log 2>/dev/null
grep -q '^TB PASSED$' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== scanout/pixelPipe.sv ====
`timescale 1ns/1ps

module pixelPipe
(
	input  logic clk,
	input  logic reset,
	input  fbPkg::cntT hCount,
	input  fbPkg::cntT vCount,
	input  logic active,
	input  logic hsyncRaw,
	input  logic vsyncRaw,
	output fbPkg::fbAddrT rdAddr,
	input  fbPkg::pixelT rdPixel,
	input  logic palWe,
	input  fbPkg::pixelT palIndex,
	input  fbPkg::colorT palColor,
	output fbPkg::colorT rgb,
	output logic hsync,
	output logic vsync,
	output logic de
);

	fbPkg::fbAddrT rowBase;
	fbPkg::fbAddrT colOff;
	fbPkg::colorT palOut;
	logic [2:0] deQ; // Bit n sits at stage n+1.
	logic [2:0] hsQ;
	logic [2:0] vsQ;

	// Scale down by 4, then row * 160 + column.
	assign rowBase = fbPkg::fbAddrT'(vCount >> fbPkg::scaleShift) *
		fbPkg::fbAddrT'(fbPkg::fbWidth);
	assign colOff = fbPkg::fbAddrT'(hCount >> fbPkg::scaleShift);

	// Stage 1. Address.
	always_ff @(posedge clk)
		rdAddr <= active ? rowBase + colOff : '0; // Park at 0 in blanking.

	////////////////////////////////////////////////////////////
	// Control delay line and output stage.
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			deQ <= '0;
			hsQ <= '1; // Syncs idle high.
			vsQ <= '1;
			de <= 1'b0;
			hsync <= 1'b1;
			vsync <= 1'b1;
			rgb <= '0;
		end
		else
		begin
			deQ <= {deQ[1:0], active};
			hsQ <= {hsQ[1:0], hsyncRaw};
			vsQ <= {vsQ[1:0], vsyncRaw};
			de <= deQ[2]; // Stage 4.
			hsync <= hsQ[2];
			vsync <= vsQ[2];
			rgb <= deQ[2] ? palOut : '0; // Black in blanking.
		end
	end

	// Stage 3. Color lookup on the bank output.
	dualPortRam #(
		.dataT(fbPkg::colorT),
		.depth(fbPkg::palDepth)
	) palette (
		.clk(clk),
		.we(palWe),
		.wrAddr(palIndex),
		.wrData(palColor),
		.rdAddr(rdPixel),
		.rdData(palOut)
	);

endmodule

// ==== scanout/vgaTiming.sv ====
`timescale 1ns/1ps

module vgaTiming
(
	input  logic clk,
	input  logic reset,
	output fbPkg::cntT hCount,
	output fbPkg::cntT vCount,
	output logic active,
	output logic hsyncRaw,
	output logic vsyncRaw,
	output logic frameEnd
);

	logic lineEnd;
	logic lastLine;

	assign lineEnd = hCount == fbPkg::cntT'(fbPkg::hTotal - 1);
	assign lastLine = vCount == fbPkg::cntT'(fbPkg::vTotal - 1);
	assign frameEnd = lineEnd && lastLine; // Last pixel of the frame.

	////////////////////////////////////////////////////////////
	// Raster counters.
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			hCount <= '0;
			vCount <= '0;
		end
		else if (lineEnd)
		begin
			hCount <= '0;
			if (lastLine)
				vCount <= '0;
			else
				vCount <= vCount + 1'b1;
		end
		else
			hCount <= hCount + 1'b1;
	end

	// Visible 640x480 window.
	assign active = (hCount < fbPkg::cntT'(fbPkg::hActive)) &&
		(vCount < fbPkg::cntT'(fbPkg::vActive));

	// Sync pulses, active low.
	assign hsyncRaw = !((hCount >= fbPkg::cntT'(fbPkg::hSyncStart)) &&
		(hCount < fbPkg::cntT'(fbPkg::hSyncEnd)));
	assign vsyncRaw = !((vCount >= fbPkg::cntT'(fbPkg::vSyncStart)) &&
		(vCount < fbPkg::cntT'(fbPkg::vSyncEnd)));

	aCountRange: assert property (@(posedge clk) disable iff (reset)
		(hCount < fbPkg::cntT'(fbPkg::hTotal)) && (vCount < fbPkg::cntT'(fbPkg::vTotal)))
		else $error("raster counter out of range");

endmodule

// ==== src/axiLiteRegs.sv ====
`timescale 1ns/1ps

module axiLiteRegs
(
	input  logic clk,
	input  logic reset,
	input  logic awvalid,
	output logic awready,
	input  logic [fbPkg::axiAddrW-1:0] awaddr,
	input  logic wvalid,
	output logic wready,
	input  logic [31:0] wdata,
	input  logic [3:0] wstrb,
	output logic bvalid,
	input  logic bready,
	output logic [1:0] bresp,
	input  logic arvalid,
	output logic arready,
	input  logic [fbPkg::axiAddrW-1:0] araddr,
	output logic rvalid,
	input  logic rready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	input  logic frontBank,
	input  logic swapPending,
	output logic pixWe,
	output fbPkg::fbAddrT pixAddr,
	output fbPkg::pixelT pixData,
	output logic palWe,
	output fbPkg::pixelT palIndex,
	output fbPkg::colorT palColor,
	output logic swapReq
);

	logic awHeld; // Address latched, waiting for data.
	logic wHeld; // Data latched, waiting for address.
	logic [fbPkg::axiAddrW-1:0] addrQ;
	logic [31:0] dataQ;
	logic [3:0] strbQ;
	logic fire; // Both halves of the write present.
	logic fullWord;
	logic isCtrl;
	logic isPixel;
	logic isPal;
	fbPkg::fbAddrT pixAddrField;

	// One write in flight. No new AW or W until the response is taken.
	assign awready = !awHeld && !bvalid;
	assign wready = !wHeld && !bvalid;
	assign arready = !rvalid;
	assign bresp = 2'b00; // Always OKAY.
	assign rresp = 2'b00;

	////////////////////////////////////////////////////////////
	// Offset decode.
	////////////////////////////////////////////////////////////
	assign fire = awHeld && wHeld;
	assign fullWord = strbQ == 4'hF; // Partial strobes are dropped.
	assign pixAddrField = dataQ[14:0];
	assign isCtrl = addrQ == fbPkg::regCtrl;
	assign isPixel = (addrQ == fbPkg::regPixel) &&
		(pixAddrField < fbPkg::fbAddrT'(fbPkg::fbPixels));
	// 0x20 to 0x3C, word aligned.
	assign isPal = (addrQ[fbPkg::axiAddrW-1:5] == fbPkg::regPaletteBase[fbPkg::axiAddrW-1:5]) &&
		(addrQ[1:0] == 2'b00);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			awHeld <= 1'b0;
			wHeld <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			pixWe <= 1'b0;
			palWe <= 1'b0;
			swapReq <= 1'b0;
		end
		else
		begin
			// Side effects pulse together with bvalid.
			pixWe <= fire && fullWord && isPixel;
			palWe <= fire && fullWord && isPal;
			swapReq <= fire && fullWord && isCtrl && dataQ[0];

			if (fire)
				awHeld <= 1'b0;
			else if (awvalid && awready)
				awHeld <= 1'b1;

			if (fire)
				wHeld <= 1'b0;
			else if (wvalid && wready)
				wHeld <= 1'b1;

			if (fire)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0; // Response taken.

			if (arvalid && arready)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	// Payload path.
	always_ff @(posedge clk)
	begin
		if (awvalid && awready)
			addrQ <= awaddr;
		if (wvalid && wready)
		begin
			dataQ <= wdata;
			strbQ <= wstrb;
		end
		if (fire)
		begin
			pixAddr <= pixAddrField;
			pixData <= dataQ[18:16]; // Index field.
			palIndex <= addrQ[4:2]; // Entry number.
			palColor <= dataQ[11:0];
		end
		if (arvalid && arready)
			rdata <= (araddr == fbPkg::regCtrl) ? {30'b0, swapPending, frontBank} : 32'b0;
	end

	aBvalidHold: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped without bready");

	aPixRange: assert property (@(posedge clk) disable iff (reset)
		pixWe |-> (pixAddr < fbPkg::fbAddrT'(fbPkg::fbPixels)))
		else $error("pixel write out of range");

endmodule

// ==== src/displayTop.sv ====
`timescale 1ns/1ps

module displayTop
(
	input  logic clk,
	input  logic reset,
	input  logic awvalid,
	output logic awready,
	input  logic [fbPkg::axiAddrW-1:0] awaddr,
	input  logic wvalid,
	output logic wready,
	input  logic [31:0] wdata,
	input  logic [3:0] wstrb,
	output logic bvalid,
	input  logic bready,
	output logic [1:0] bresp,
	input  logic arvalid,
	output logic arready,
	input  logic [fbPkg::axiAddrW-1:0] araddr,
	output logic rvalid,
	input  logic rready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output fbPkg::colorT rgb,
	output logic hsync,
	output logic vsync,
	output logic de
);

	// Painter side.
	logic pixWe;
	fbPkg::fbAddrT pixAddr;
	fbPkg::pixelT pixData;
	logic palWe;
	fbPkg::pixelT palIndex;
	fbPkg::colorT palColor;
	logic swapReq;
	logic frontBank;
	logic swapPending;

	// Scanout side.
	fbPkg::cntT hCount;
	fbPkg::cntT vCount;
	logic active;
	logic hsyncRaw;
	logic vsyncRaw;
	logic frameEnd;
	fbPkg::fbAddrT rdAddr;
	fbPkg::pixelT rdPixel;

	////////////////////////////////////////////////////////////
	// Register slave and frame store.
	////////////////////////////////////////////////////////////
	axiLiteRegs regs (.*);

	frameBuffer fb (.*);

	// Raster and pixel pipeline.
	vgaTiming timing (.*);

	pixelPipe pipe (.*);

endmodule

// ==== test/tbTasks.svh ====
`ifndef tbTasksSvh
`define tbTasksSvh

// Model of both banks and the palette.
fbPkg::pixelT bankModel [2][fbPkg::fbPixels] = '{default: '0};
fbPkg::colorT palModel [fbPkg::palDepth] = '{default: '0};
logic modelFront = 1'b0; // Bank the model shows.

// Screen pixel (x, y). Each stored pixel covers a 4x4 block.
function automatic fbPkg::colorT expectedRgb(input int x, input int y);
	if (x < 0 || y < 0 || x >= fbPkg::hActive || y >= fbPkg::vActive)
		return '1; // Off screen.
	return palModel[bankModel[modelFront][(y / 4) * fbPkg::fbWidth + x / 4]];
endfunction

////////////////////////////////////////////////////////////
// AXI4-Lite master. Readies sampled at the falling edge.
////////////////////////////////////////////////////////////
task automatic waitAddrData();
	int t;
	logic awGo;
	logic wGo;
	for (t = 0; (awvalid || wvalid) && t < 50; t++)
	begin
		@(negedge clk);
		awGo = awvalid && awready; // Transfer at the next edge.
		wGo = wvalid && wready;
		@(posedge clk);
		#1;
		if (awGo)
			awvalid = 1'b0;
		if (wGo)
			wvalid = 1'b0;
	end
	if (awvalid || wvalid)
		noteTimeout("the write address and data handshakes");
	awvalid = 1'b0;
	wvalid = 1'b0;
endtask

task automatic waitResponse();
	int t;
	logic taken;
	taken = 1'b0;
	for (t = 0; !taken && t < 50; t++)
	begin
		@(negedge clk);
		taken = bvalid && bready;
		if (taken)
			checkValue("bresp", bresp, 0); // OKAY.
		@(posedge clk);
		#1;
	end
	if (!taken)
		noteTimeout("the write response");
endtask

task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data);
	awaddr = addr;
	wdata = data;
	wstrb = 4'hF;
	awvalid = 1'b1;
	wvalid = 1'b1;
	bready = 1'b1;
	waitAddrData();
	waitResponse();
endtask

task automatic axiRead(input logic [7:0] addr, output logic [31:0] data);
	int t;
	logic taken;
	araddr = addr;
	arvalid = 1'b1;
	rready = 1'b1;
	taken = 1'b0;
	data = '0;
	for (t = 0; arvalid && t < 50; t++)
	begin
		@(negedge clk);
		taken = arready;
		@(posedge clk);
		#1;
		if (taken)
			arvalid = 1'b0;
	end
	if (arvalid)
		noteTimeout("the read address handshake");
	taken = 1'b0;
	for (t = 0; !taken && t < 50; t++)
	begin
		@(negedge clk);
		taken = rvalid; // Held until rready.
		data = rdata;
		if (taken)
			checkValue("rresp", rresp, 0);
		@(posedge clk);
		#1;
	end
	if (!taken)
		noteTimeout("the read data");
	arvalid = 1'b0;
endtask

// Painter helpers. The model follows each completed write.
task automatic writePalette(input fbPkg::pixelT idx, input fbPkg::colorT color);
	axiWrite(fbPkg::regPaletteBase + 8'(idx) * 8'd4, 32'(color));
	palModel[idx] = color;
endtask

task automatic paintRandom(input int count);
	fbPkg::fbAddrT addr;
	fbPkg::pixelT idx;
	for (int i = 0; i < count; i++)
	begin
		addr = fbPkg::fbAddrT'($unsigned($random(seed)) % fbPkg::fbPixels);
		idx = fbPkg::pixelT'($random(seed));
		axiWrite(fbPkg::regPixel, {13'b0, idx, 1'b0, addr});
		bankModel[!modelFront][addr] = idx; // Back bank only.
	end
endtask

// First response held back while a second write waits.
task automatic stalledPaletteWrites(input fbPkg::pixelT idxA, input fbPkg::colorT colorA,
	input fbPkg::pixelT idxB, input fbPkg::colorT colorB);
	int t;
	bready = 1'b0;
	awaddr = fbPkg::regPaletteBase + 8'(idxA) * 8'd4;
	wdata = 32'(colorA);
	wstrb = 4'hF;
	awvalid = 1'b1;
	wvalid = 1'b1;
	waitAddrData();
	for (t = 0; !bvalid && t < 50; t++)
	begin
		@(posedge clk);
		#1;
	end
	if (!bvalid)
		noteTimeout("bvalid with bready low");
	awaddr = fbPkg::regPaletteBase + 8'(idxB) * 8'd4;
	wdata = 32'(colorB);
	awvalid = 1'b1;
	wvalid = 1'b1;
	repeat (8)
	begin
		@(negedge clk);
		checkValue("bvalid", bvalid, 1);
		checkValue("awready", awready, 0); // Second write blocked.
		checkValue("wready", wready, 0);
		@(posedge clk);
		#1;
	end
	bready = 1'b1;
	waitResponse();
	waitAddrData();
	waitResponse();
	palModel[idxA] = colorA;
	palModel[idxB] = colorB;
endtask

`endif

// ==== test/displayTb.sv ====
`timescale 1ns/1ps

module displayTb;

	logic clk = 1'b0;
	logic reset;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic [fbPkg::axiAddrW-1:0] awaddr;
	logic [fbPkg::axiAddrW-1:0] araddr;
	logic [31:0] wdata;
	logic [31:0] rdata;
	logic [3:0] wstrb;
	logic [1:0] bresp;
	logic [1:0] rresp;
	logic arvalid, arready, rvalid, rready;
	fbPkg::colorT rgb;
	logic hsync, vsync, de;

	int seed = 39889;
	int checks = 0;
	int errors = 0;
	int timeouts = 0;
	int cmpCount = 0; // Pixels compared in total.
	logic checkOn = 1'b0; // Frames picked by the sequencer.
	logic geomOn = 1'b0;
	logic [31:0] status;

	// Checker state.
	int x = 0;
	int y = -1;
	int cyc = 0;
	int lastHsFall = 0;
	int deRun = 0;
	int deLines = 0;
	int vsLines = 0;
	logic prevVs = 1'b1;
	logic prevHs = 1'b1;
	logic prevDe = 1'b0;
	logic measuring = 1'b0;
	fbPkg::colorT expColor;

	displayTop DUT (.*);

	always #5 clk = !clk; // 10 ns period.

	task automatic noteTimeout(input string what);
		timeouts++;
		$display("timeout at time %0t while waiting for %s", $time, what);
	endtask

	task automatic checkValue(input string name, input int got, input int exp);
		checks++;
		assert (got == exp)
		else
		begin
			errors++;
			$display("mismatch at time %0t: %s expected %0d got %0d", $time, name, exp, got);
		end
	endtask

	`include "tbTasks.svh"

	////////////////////////////////////////////////////////////
	// Scanout checker on the aligned outputs.
	////////////////////////////////////////////////////////////
	always @(negedge clk)
	begin
		cyc++;
		if (!reset)
		begin
			if (prevVs && !vsync) // Frame boundary.
			begin
				if (measuring)
					checkValue("lines with de", deLines, fbPkg::vActive);
				measuring = geomOn; // Latched for the whole frame.
				deLines = 0;
				vsLines = 0;
				y = -1;
			end
			if (!prevVs && vsync && measuring)
				checkValue("vsync lines", vsLines, fbPkg::vSync);
			if (prevHs && !hsync)
			begin
				if (measuring)
					checkValue("hsync period", cyc - lastHsFall, fbPkg::hTotal);
				lastHsFall = cyc;
				if (!vsync)
					vsLines++;
			end
			if (!prevHs && hsync && measuring)
				checkValue("hsync pulse", cyc - lastHsFall, fbPkg::hSync);
			if (de && !prevDe) // New line.
			begin
				y++;
				x = 0;
				deRun = 0;
				deLines++;
			end
			if (de && checkOn)
			begin
				expColor = expectedRgb(x, y);
				cmpCount++;
				checks++;
				assert (rgb == expColor)
				else
				begin
					errors++;
					$display("mismatch at time %0t: rgb at (%0d,%0d) expected %h got %h",
						$time, x, y, expColor, rgb);
				end
			end
			if (!de && prevDe && measuring)
				checkValue("de cycles per line", deRun, fbPkg::hActive);
			if (de)
			begin
				x++;
				deRun++;
			end
			prevVs = vsync;
			prevHs = hsync;
			prevDe = de;
		end
	end

	task automatic waitVsyncFall();
		int t;
		logic seen;
		logic last;
		seen = 1'b0;
		last = vsync;
		for (t = 0; !seen && t < 2 * fbPkg::hTotal * fbPkg::vTotal; t++)
		begin
			@(posedge clk);
			#1;
			seen = last && !vsync;
			last = vsync;
		end
		if (!seen)
			noteTimeout("the vsync falling edge");
	endtask

	// Compare one whole frame. Called in vertical blank.
	task automatic checkFrame();
		checkOn = 1'b1;
		waitVsyncFall();
		checkOn = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Sequencer.
	////////////////////////////////////////////////////////////
	initial
	begin
		reset = 1'b1;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;

		// Idle outputs straight after reset.
		checkValue("bvalid", bvalid, 0);
		checkValue("rvalid", rvalid, 0);
		checkValue("de", de, 0);
		checkValue("hsync", hsync, 1);
		checkValue("vsync", vsync, 1);
		axiRead(fbPkg::regCtrl, status);
		checkValue("status", status, 0);

		// Palette plus a partial image in the back bank. Front still blank.
		for (int i = 0; i < fbPkg::palDepth; i++)
			writePalette(fbPkg::pixelT'(i), fbPkg::colorT'($random(seed)));
		paintRandom(3000);
		waitVsyncFall();
		geomOn = 1'b1; // Sync geometry on this frame too.
		checkFrame();
		geomOn = 1'b0;

		// First swap, deferred to frame end.
		axiWrite(fbPkg::regCtrl, 32'h1);
		axiRead(fbPkg::regCtrl, status);
		checkValue("status", status, 2); // Pending, bank 0 shown.
		modelFront = 1'b1;
		checkFrame();
		axiRead(fbPkg::regCtrl, status);
		checkValue("status", status, 1);

		// Painting the new back bank must not show.
		checkOn = 1'b1;
		paintRandom(2000);
		waitVsyncFall();
		checkOn = 1'b0;
		axiWrite(fbPkg::regCtrl, 32'h1);
		modelFront = 1'b0;
		checkFrame();
		axiRead(fbPkg::regCtrl, status);
		checkValue("status", status, 0);

		// Held write response, then new colors on screen.
		stalledPaletteWrites(3'd0, palModel[0] ^ 12'h5A5, 3'd1, palModel[1] ^ 12'hA5A);
		checkFrame();

		checkValue("compared pixels", cmpCount, 5 * fbPkg::hActive * fbPkg::vActive);
		$display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule
